// ==== logic/bb_pkg.sv ====
`default_nettype none

package bb_pkg;

  // header field widths
  typedef logic [2:0] lt_addr_t;
  typedef logic [3:0] pk_type_t;
  typedef logic [7:0] uap_t;
  typedef logic [7:0] hec_t;
  typedef logic [6:0] wh_state_t;
  typedef logic [5:0] clk_seed_t;

  // LT_ADDR, TYPE, FLOW, ARQN, SEQN
  localparam int HDR_INFO_BITS = 10;
  localparam int HDR_BITS      = HDR_INFO_BITS + $bits(hec_t);

  // D8+D7+D5+D2+D+1, D8 term implied by the shift out
  localparam hec_t HEC_POLY = 8'b1010_0111;

  // D7+D4+1, D7 term implied
  localparam wh_state_t WH_POLY = 7'b001_0001;

  // whitening seed always carries a one above CLK[6:1]
  localparam wh_state_t WH_TOP = 7'b100_0000;

  // shared by both header sequencers
  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } hdr_state_t;

endpackage

`default_nettype wire

// ==== logic/lfsr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lfsr_if #(
  parameter int WIDTH = 8
);

  logic             load;
  logic [WIDTH-1:0] seed;
  logic             step;
  logic [WIDTH-1:0] state;

  modport user (output load, seed, step, input state);
  modport core (input load, seed, step, output state);

endinterface

`default_nettype wire

// ==== logic/hec_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module hec_gen import bb_pkg::*; (
  input  logic   clk_6M,
  input  logic   rstz,
  lfsr_if.core   lfsr,
  input  logic   din
);

  hec_t hec_q;
  logic fb;

  assign fb = din ^ hec_q[$bits(hec_t)-1];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hec_q <= '0;
    else if (lfsr.load)
      hec_q <= lfsr.seed;   // uap seed
    else if (lfsr.step)
    begin
      if (fb)
        hec_q <= {hec_q[$bits(hec_t)-2:0], 1'b0} ^ HEC_POLY;
      else
        hec_q <= {hec_q[$bits(hec_t)-2:0], 1'b0};
    end
  end

  assign lfsr.state = hec_q;

endmodule

`default_nettype wire

// ==== logic/whitener.sv ====
`timescale 1ns/1ps
`default_nettype none

module whitener import bb_pkg::*; (
  input  logic clk_6M,
  input  logic rstz,
  lfsr_if.core lfsr
);

  wh_state_t wh_q;
  logic      msb;

  assign msb = wh_q[$bits(wh_state_t)-1];

  // galois form, msb is the whitening bit
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      wh_q <= '0;
    else if (lfsr.load)
      wh_q <= lfsr.seed;
    else if (lfsr.step)
    begin
      if (msb)
        wh_q <= {wh_q[$bits(wh_state_t)-2:0], 1'b0} ^ WH_POLY;
      else
        wh_q <= {wh_q[$bits(wh_state_t)-2:0], 1'b0};
    end
  end

  assign lfsr.state = wh_q;

endmodule

`default_nettype wire

// ==== logic/header_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module header_tx import bb_pkg::*; #(
  parameter int REP_FACTOR = 3
) (
  input  logic      clk_6M,
  input  logic      rstz,
  input  logic      bit_tick,
  input  logic      tx_st_p,
  input  logic      whiten_en,
  input  uap_t      uap,
  input  clk_seed_t clk_seed,
  input  lt_addr_t  tx_lt_addr,
  input  pk_type_t  tx_pk_type,
  input  logic      tx_flow,
  input  logic      tx_arqn,
  input  logic      tx_seqn,
  output logic      txbit,
  output logic      txbit_period
);

  localparam int CNT_W = $clog2(HDR_BITS);
  localparam int REP_W = $clog2(REP_FACTOR + 1);

  hdr_state_t               state;
  logic [CNT_W-1:0]         hdr_cnt;
  logic [REP_W-1:0]         rep_cnt;
  logic [HDR_INFO_BITS-1:0] info_q;
  logic                     whiten_q;
  logic                     start;
  logic                     bit_adv;
  logic                     hec_phase;
  logic                     hdr_bit;

  lfsr_if #(.WIDTH($bits(hec_t)))      hec_if ();
  lfsr_if #(.WIDTH($bits(wh_state_t))) wh_if ();

  assign start     = tx_st_p && (state == ST_IDLE);
  assign bit_adv   = bit_tick && (state == ST_BUSY) && (rep_cnt == REP_W'(REP_FACTOR - 1));
  assign hec_phase = (hdr_cnt >= CNT_W'(HDR_INFO_BITS));

  // din equal to the msb turns a step into a plain shift for the hec bits
  assign hdr_bit = hec_phase ? hec_if.state[$bits(hec_t)-1] : info_q[0];

  assign hec_if.load = start;
  assign hec_if.seed = uap;
  assign hec_if.step = bit_adv;
  assign wh_if.load  = start;
  assign wh_if.seed  = WH_TOP | wh_state_t'(clk_seed);
  assign wh_if.step  = bit_adv;   // steps even with whitening off

  hec_gen hec_gen_i (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .lfsr   (hec_if),
    .din    (hdr_bit)
  );

  whitener whitener_i (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .lfsr   (wh_if)
  );

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state   <= ST_IDLE;
      hdr_cnt <= '0;
      rep_cnt <= '0;
    end
    else if (start)
    begin
      state   <= ST_BUSY;
      hdr_cnt <= '0;
      rep_cnt <= '0;
    end
    else if (bit_tick && (state == ST_BUSY))
    begin
      if (bit_adv)
      begin
        rep_cnt <= '0;
        hdr_cnt <= hdr_cnt + 1'b1;
        if (hdr_cnt == CNT_W'(HDR_BITS - 1))
          state <= ST_IDLE;
      end
      else
        rep_cnt <= rep_cnt + 1'b1;
    end
  end

  // lsb goes out first
  always_ff @(posedge clk_6M)
  begin
    if (start)
    begin
      info_q   <= {tx_seqn, tx_arqn, tx_flow, tx_pk_type, tx_lt_addr};
      whiten_q <= whiten_en;
    end
    else if (bit_adv)
      info_q <= info_q >> 1;
  end

  assign txbit_period = (state == ST_BUSY);
  assign txbit = txbit_period & (hdr_bit ^ (whiten_q & wh_if.state[$bits(wh_state_t)-1]));

endmodule

`default_nettype wire

// ==== logic/header_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module header_rx import bb_pkg::*; #(
  parameter int REP_FACTOR = 3
) (
  input  logic      clk_6M,
  input  logic      rstz,
  input  logic      bit_tick,
  input  logic      rx_st_p,
  input  logic      whiten_en,
  input  uap_t      uap,
  input  clk_seed_t clk_seed,
  input  lt_addr_t  my_lt_addr,
  input  logic      rxbit,
  output logic      hdr_done_p,
  output logic      hec_good,
  output logic      lt_addressed,
  output lt_addr_t  dec_lt_addr,
  output pk_type_t  dec_pk_type,
  output logic      dec_flow,
  output logic      dec_arqn,
  output logic      dec_seqn
);

  localparam int CNT_W = $clog2(HDR_BITS);
  localparam int REP_W = $clog2(REP_FACTOR + 1);

  hdr_state_t               state;
  logic [CNT_W-1:0]         hdr_cnt;
  logic [REP_W-1:0]         rep_cnt;
  logic [REP_W-1:0]         ones_cnt;
  logic [REP_W-1:0]         ones_tot;
  logic [HDR_INFO_BITS-1:0] field_q;
  logic                     whiten_q;
  logic                     err_q;
  logic                     start;
  logic                     sample;
  logic                     bit_adv;
  logic                     hdr_end;
  logic                     hec_phase;
  logic                     voted;
  logic                     dbit;
  logic                     hec_msb;
  logic                     hec_ok;

  lfsr_if #(.WIDTH($bits(hec_t)))      hec_if ();
  lfsr_if #(.WIDTH($bits(wh_state_t))) wh_if ();

  assign start     = rx_st_p && (state == ST_IDLE);
  assign sample    = bit_tick && (state == ST_BUSY);
  assign bit_adv   = sample && (rep_cnt == REP_W'(REP_FACTOR - 1));
  assign hdr_end   = bit_adv && (hdr_cnt == CNT_W'(HDR_BITS - 1));
  assign hec_phase = (hdr_cnt >= CNT_W'(HDR_INFO_BITS));

  // majority over the group including the bit sampled now
  assign ones_tot = ones_cnt + REP_W'(rxbit);
  assign voted    = (ones_tot > REP_W'(REP_FACTOR / 2));
  assign dbit     = voted ^ (whiten_q & wh_if.state[$bits(wh_state_t)-1]);
  assign hec_msb  = hec_if.state[$bits(hec_t)-1];
  assign hec_ok   = !(err_q || (dbit ^ hec_msb));   // last bit is always a hec bit

  assign hec_if.load = start;
  assign hec_if.seed = uap;
  assign hec_if.step = bit_adv;
  assign wh_if.load  = start;
  assign wh_if.seed  = WH_TOP | wh_state_t'(clk_seed);
  assign wh_if.step  = bit_adv;

  hec_gen hec_gen_i (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .lfsr   (hec_if),
    .din    (hec_phase ? hec_msb : dbit)
  );

  whitener whitener_i (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .lfsr   (wh_if)
  );

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state    <= ST_IDLE;
      hdr_cnt  <= '0;
      rep_cnt  <= '0;
      ones_cnt <= '0;
      err_q    <= 1'b0;
    end
    else if (start)
    begin
      state    <= ST_BUSY;
      hdr_cnt  <= '0;
      rep_cnt  <= '0;
      ones_cnt <= '0;
      err_q    <= 1'b0;
    end
    else if (sample)
    begin
      if (bit_adv)
      begin
        rep_cnt  <= '0;
        ones_cnt <= '0;
        hdr_cnt  <= hdr_cnt + 1'b1;
        if (hec_phase)
          err_q <= err_q | (dbit ^ hec_msb);
        if (hdr_end)
          state <= ST_IDLE;
      end
      else
      begin
        rep_cnt  <= rep_cnt + 1'b1;
        ones_cnt <= ones_tot;
      end
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hdr_done_p   <= 1'b0;
      hec_good     <= 1'b0;
      lt_addressed <= 1'b0;
    end
    else
    begin
      hdr_done_p <= hdr_end;
      if (hdr_end)
      begin
        hec_good     <= hec_ok;
        lt_addressed <= hec_ok && (field_q[2:0] == my_lt_addr);
      end
    end
  end

  // first info bit ends up in bit 0
  always_ff @(posedge clk_6M)
  begin
    if (start)
      whiten_q <= whiten_en;
    if (bit_adv && !hec_phase)
      field_q <= {dbit, field_q[HDR_INFO_BITS-1:1]};
    if (hdr_end)
    begin
      dec_lt_addr <= field_q[2:0];
      dec_pk_type <= field_q[6:3];
      dec_flow    <= field_q[7];
      dec_arqn    <= field_q[8];
      dec_seqn    <= field_q[9];
    end
  end

endmodule

`default_nettype wire

// ==== logic/bb_header_bitp.sv ====
`timescale 1ns/1ps
`default_nettype none

module bb_header_bitp import bb_pkg::*; #(
  parameter int REP_FACTOR = 3   // odd, 1/3 fec by default
) (
  input  logic      clk_6M,
  input  logic      rstz,
  input  logic      bit_tick,
  input  logic      tx_st_p,
  input  logic      rx_st_p,
  input  logic      whiten_en,
  input  uap_t      uap,
  input  clk_seed_t clk_seed,
  input  lt_addr_t  tx_lt_addr,
  input  pk_type_t  tx_pk_type,
  input  logic      tx_flow,
  input  logic      tx_arqn,
  input  logic      tx_seqn,
  input  lt_addr_t  my_lt_addr,
  input  logic      rxbit,
  output logic      txbit,
  output logic      txbit_period,
  output logic      hdr_done_p,
  output logic      hec_good,
  output logic      lt_addressed,
  output lt_addr_t  dec_lt_addr,
  output pk_type_t  dec_pk_type,
  output logic      dec_flow,
  output logic      dec_arqn,
  output logic      dec_seqn
);

  header_tx #(.REP_FACTOR(REP_FACTOR)) header_tx_i (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .bit_tick     (bit_tick),
    .tx_st_p      (tx_st_p),
    .whiten_en    (whiten_en),
    .uap          (uap),
    .clk_seed     (clk_seed),
    .tx_lt_addr   (tx_lt_addr),
    .tx_pk_type   (tx_pk_type),
    .tx_flow      (tx_flow),
    .tx_arqn      (tx_arqn),
    .tx_seqn      (tx_seqn),
    .txbit        (txbit),
    .txbit_period (txbit_period)
  );

  header_rx #(.REP_FACTOR(REP_FACTOR)) header_rx_i (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .bit_tick     (bit_tick),
    .rx_st_p      (rx_st_p),
    .whiten_en    (whiten_en),
    .uap          (uap),
    .clk_seed     (clk_seed),
    .my_lt_addr   (my_lt_addr),
    .rxbit        (rxbit),
    .hdr_done_p   (hdr_done_p),
    .hec_good     (hec_good),
    .lt_addressed (lt_addressed),
    .dec_lt_addr  (dec_lt_addr),
    .dec_pk_type  (dec_pk_type),
    .dec_flow     (dec_flow),
    .dec_arqn     (dec_arqn),
    .dec_seqn     (dec_seqn)
  );

endmodule

`default_nettype wire

// ==== verif/tb_header_model.svh ====
`ifndef TB_HEADER_MODEL_SVH
`define TB_HEADER_MODEL_SVH

// register starts at the uap, info bits lsb first
function automatic logic [7:0] model_hec(input logic [7:0] seed, input logic [9:0] info);
  logic [7:0] r;
  logic       fb;
  int         i;
  r = seed;
  for (i = 0; i < 10; i++)
  begin
    fb = info[i] ^ r[7];
    r  = {r[6:0], 1'b0};
    if (fb)
      r = r ^ 8'b1010_0111;   // D8+D7+D5+D2+D+1
  end
  return r;
endfunction

// bits in send order, hec goes out msb first
function automatic logic [17:0] hdr_bits(input logic [9:0] info, input logic [7:0] seed);
  logic [17:0] h;
  logic [7:0]  hec;
  int          k;
  hec = model_hec(seed, info);
  h[9:0] = info;
  for (k = 0; k < 8; k++)
    h[10+k] = hec[7-k];
  return h;
endfunction

function automatic logic [17:0] wh_mask(input logic [5:0] seed, input logic en);
  logic [6:0]  w;
  logic [17:0] m;
  logic        msb;
  int          i;
  w = {1'b1, seed};
  for (i = 0; i < 18; i++)
  begin
    m[i] = w[6] & en;
    msb  = w[6];
    w    = {w[5:0], 1'b0};
    if (msb)
      w = w ^ 7'b001_0001;   // D7+D4+1
  end
  return m;
endfunction

function automatic logic [CHAN_BITS-1:0] fec_expand(input logic [17:0] h);
  logic [CHAN_BITS-1:0] c;
  int                   i;
  for (i = 0; i < CHAN_BITS; i++)
    c[i] = h[i / REP];
  return c;
endfunction

function automatic logic hec_matches(input logic [17:0] h, input logic [7:0] seed);
  logic [7:0] rx_hec;
  int         k;
  for (k = 0; k < 8; k++)
    rx_hec[7-k] = h[10+k];
  return rx_hec == model_hec(seed, h[9:0]);
endfunction

// galois form, taps x16+x14+x13+x11+1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  logic lsb;
  lsb = s[0];
  s   = s >> 1;
  if (lsb)
    s = s ^ 16'hB400;
  return s;
endfunction

`endif

// ==== verif/tb_bb_header_bitp.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bb_header_bitp import bb_pkg::*;;

  localparam int REP       = 3;
  localparam int CHAN_BITS = 18 * REP;

  logic      clk_6M;
  logic      rstz;
  logic      bit_tick;
  logic      tx_st_p;
  logic      rx_st_p;
  logic      whiten_en;
  uap_t      uap;
  clk_seed_t clk_seed;
  lt_addr_t  tx_lt_addr;
  pk_type_t  tx_pk_type;
  logic      tx_flow;
  logic      tx_arqn;
  logic      tx_seqn;
  lt_addr_t  my_lt_addr;
  logic      rxbit;
  logic      txbit;
  logic      txbit_period;
  logic      hdr_done_p;
  logic      hec_good;
  logic      lt_addressed;
  lt_addr_t  dec_lt_addr;
  pk_type_t  dec_pk_type;
  logic      dec_flow;
  logic      dec_arqn;
  logic      dec_seqn;
  logic [15:0] lfsr_q;
  int          tick_cnt;

  `include "tb_header_model.svh"

  bb_header_bitp #(.REP_FACTOR(REP)) bb_header_bitp_i (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .bit_tick     (bit_tick),
    .tx_st_p      (tx_st_p),
    .rx_st_p      (rx_st_p),
    .whiten_en    (whiten_en),
    .uap          (uap),
    .clk_seed     (clk_seed),
    .tx_lt_addr   (tx_lt_addr),
    .tx_pk_type   (tx_pk_type),
    .tx_flow      (tx_flow),
    .tx_arqn      (tx_arqn),
    .tx_seqn      (tx_seqn),
    .my_lt_addr   (my_lt_addr),
    .rxbit        (rxbit),
    .txbit        (txbit),
    .txbit_period (txbit_period),
    .hdr_done_p   (hdr_done_p),
    .hec_good     (hec_good),
    .lt_addressed (lt_addressed),
    .dec_lt_addr  (dec_lt_addr),
    .dec_pk_type  (dec_pk_type),
    .dec_flow     (dec_flow),
    .dec_arqn     (dec_arqn),
    .dec_seqn     (dec_seqn)
  );

  always #10 clk_6M = ~clk_6M;

  // one tick every 6 cycles
  always @(posedge clk_6M)
  begin
    #1;
    if (!rstz)
    begin
      tick_cnt = 0;
      bit_tick = 1'b0;
    end
    else
    begin
      bit_tick = (tick_cnt == 5);
      tick_cnt = (tick_cnt == 5) ? 0 : tick_cnt + 1;
    end
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
      stop_run($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [9:0] cur_info();
    return {tx_seqn, tx_arqn, tx_flow, tx_pk_type, tx_lt_addr};
  endfunction

  task automatic randomize_header();
    @(posedge clk_6M);
    #1;
    tx_lt_addr = rand_bits(3);
    tx_pk_type = rand_bits(4);
    tx_flow    = rand_bits(1);
    tx_arqn    = rand_bits(1);
    tx_seqn    = rand_bits(1);
    uap        = rand_bits(8);
    clk_seed   = rand_bits(6);
    whiten_en  = rand_bits(1);
    if (rand_bits(1))
      my_lt_addr = tx_lt_addr;   // hit the addressed case often
    else
      my_lt_addr = rand_bits(3);
  endtask

  // returns at the negedge where bit_tick is high
  task automatic wait_tick(input string what);
    logic seen;
    int   n;
    seen = 1'b0;
    for (n = 0; n < 20 && !seen; n++)
    begin
      @(negedge clk_6M);
      seen = bit_tick;
    end
    if (!seen)
      stop_run({"no bit_tick arrived while waiting for ", what});
  endtask

  task automatic pulse_start(input logic is_rx);
    wait_tick("a start slot");
    @(posedge clk_6M);
    #1;
    if (is_rx)
      rx_st_p = 1'b1;
    else
      tx_st_p = 1'b1;
    @(posedge clk_6M);
    #1;
    rx_st_p = 1'b0;
    tx_st_p = 1'b0;
  endtask

  task automatic tx_test();
    logic [CHAN_BITS-1:0] chan;
    int                   k;
    randomize_header();
    chan = fec_expand(hdr_bits(cur_info(), uap) ^ wh_mask(clk_seed, whiten_en));
    pulse_start(1'b0);
    for (k = 0; k < CHAN_BITS; k++)
    begin
      wait_tick("a tx bit");
      compare_value($sformatf("tx period %0d", k), 1, txbit_period);
      compare_value($sformatf("tx bit %0d", k), chan[k], txbit);
      if (k == 20)
      begin
        randomize_header();   // restart attempt while busy
        tx_st_p = 1'b1;
        @(posedge clk_6M);
        #1 tx_st_p = 1'b0;
      end
    end
    @(negedge clk_6M);
    compare_value("tx period end", 0, txbit_period);
    compare_value("tx bit idle", 0, txbit);
  endtask

  task automatic send_rx(input logic [CHAN_BITS-1:0] chan);
    logic done;
    int   k;
    int   n;
    pulse_start(1'b1);
    rxbit = chan[0];
    for (k = 0; k < CHAN_BITS; k++)
    begin
      wait_tick("an rx bit");
      @(posedge clk_6M);
      #1 rxbit = (k + 1 < CHAN_BITS) ? chan[k+1] : 1'b0;
    end
    done = 1'b0;
    for (n = 0; n < 8 && !done; n++)
    begin
      @(negedge clk_6M);
      done = hdr_done_p;
    end
    if (!done)
      stop_run("hdr_done_p never pulsed after the last header bit");
  endtask

  task automatic verify_rx_result(input logic [9:0] info, input logic good);
    compare_value("dec_lt_addr", info[2:0], dec_lt_addr);
    compare_value("dec_pk_type", info[6:3], dec_pk_type);
    compare_value("dec_flow", info[7], dec_flow);
    compare_value("dec_arqn", info[8], dec_arqn);
    compare_value("dec_seqn", info[9], dec_seqn);
    compare_value("hec_good", good, hec_good);
    compare_value("lt_addressed", good && (info[2:0] == my_lt_addr), lt_addressed);
    @(negedge clk_6M);
    compare_value("hdr_done_p width", 0, hdr_done_p);
  endtask

  // mode 0 clean, 1 single errors per group, 2 broken hec bit
  task automatic rx_test(input int mode);
    logic [CHAN_BITS-1:0] chan;
    logic [9:0]           info;
    int                   g;
    int                   pos;
    randomize_header();
    info = cur_info();
    chan = fec_expand(hdr_bits(info, uap) ^ wh_mask(clk_seed, whiten_en));
    if (mode == 1)
    begin
      for (g = 0; g < 18; g++)
      begin
        if (rand_bits(1))
        begin
          pos = rand_bits(2) % REP;
          chan[g*REP+pos] = ~chan[g*REP+pos];
        end
      end
    end
    else if (mode == 2)
    begin
      g = 10 + rand_bits(3);
      chan[g*REP]   = ~chan[g*REP];
      chan[g*REP+1] = ~chan[g*REP+1];
    end
    send_rx(chan);
    verify_rx_result(info, mode != 2);
  endtask

  task automatic seed_test();
    logic [5:0]  tx_seed;
    logic [5:0]  delta;
    logic [17:0] hdr;
    logic [17:0] dw;
    randomize_header();
    whiten_en = 1'b1;
    tx_seed   = clk_seed;
    delta     = rand_bits(6);
    if (delta == 6'd0)
      delta = 6'd1;
    clk_seed = tx_seed ^ delta;
    hdr = hdr_bits(cur_info(), uap) ^ wh_mask(tx_seed, 1'b1);
    dw  = hdr ^ wh_mask(clk_seed, 1'b1);   // what the dut dewhitens
    send_rx(fec_expand(hdr));
    verify_rx_result(dw[9:0], hec_matches(dw, uap));
  endtask

  initial
  begin
    lfsr_q     = 16'd28154;
    clk_6M     = 1'b0;
    rstz       = 1'b0;
    bit_tick   = 1'b0;
    tx_st_p    = 1'b0;
    rx_st_p    = 1'b0;
    whiten_en  = 1'b0;
    uap        = '0;
    clk_seed   = '0;
    tx_lt_addr = '0;
    tx_pk_type = '0;
    tx_flow    = 1'b0;
    tx_arqn    = 1'b0;
    tx_seqn    = 1'b0;
    my_lt_addr = '0;
    rxbit      = 1'b0;
    repeat (5) @(posedge clk_6M);
    #1 rstz = 1'b1;
    @(negedge clk_6M);
    compare_value("reset txbit_period", 0, txbit_period);
    compare_value("reset txbit", 0, txbit);
    compare_value("reset hdr_done_p", 0, hdr_done_p);
    compare_value("reset hec_good", 0, hec_good);
    compare_value("reset lt_addressed", 0, lt_addressed);
    repeat (4) tx_test();
    repeat (4) rx_test(0);
    repeat (4) rx_test(1);
    repeat (3) rx_test(2);
    repeat (3) seed_test();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verif
logic/bb_pkg.sv
logic/lfsr_if.sv
logic/hec_gen.sv
logic/whitener.sv
logic/header_tx.sv
logic/header_rx.sv
logic/bb_header_bitp.sv
verif/tb_bb_header_bitp.sv

// ==== Bender.yml ====
package:
  name: bb_header_bitp

sources:
  - logic/bb_pkg.sv
  - logic/lfsr_if.sv
  - logic/hec_gen.sv
  - logic/whitener.sv
  - logic/header_tx.sv
  - logic/header_rx.sv
  - logic/bb_header_bitp.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_bb_header_bitp.sv
